// File: logic/pss_settings.svh
`ifndef PSS_SETTINGS_SVH
`define PSS_SETTINGS_SVH

// width of one I or Q component
`define PSS_IQ_W 8

// taps per correlation window, in decimated samples
`define PSS_WIN_LEN 16

`define PSS_METRIC_W 14 // |I| + |Q| of the window sums
`define PSS_POS_W 16 // decimated sample counter, wraps

// result events ignored after a detection
`define PSS_HOLDOFF 8

`define PSS_NUM_HYP 3 // N_id_2 = 0, 1, 2

`endif

// File: logic/pss_pkg.sv
`include "pss_settings.svh"

package pss_pkg;

    // I in the high byte, Q in the low byte
    typedef struct packed {
        logic signed [`PSS_IQ_W-1:0] i;
        logic signed [`PSS_IQ_W-1:0] q;
    } iq_sample_t;

    typedef struct packed {
        logic [`PSS_METRIC_W-1:0] metric;
        logic [`PSS_POS_W-1:0]    pos; // position of the newest window sample
        logic                     valid;
    } corr_result_t;

    typedef enum logic {
        SEARCH,
        HOLD
    } picker_state_t;

    // PSS m-sequence bit, 0 means +1 and 1 means -1
    function automatic logic pss_tap_bit(input int unsigned idx, input int unsigned n_id_2);
        logic [126:0] x;
        int unsigned  k;
        x = '0;
        x[6:0] = 7'b1110110; // x(6) down to x(0)
        for (int unsigned n = 0; n < 120; n++) begin
            x[n+7] = x[n+4] ^ x[n];
        end
        k = (idx + 43 * n_id_2) % 127;
        return x[k];
    endfunction

endpackage

// File: logic/dec_if.sv
`timescale 1ns/1ns
`include "pss_settings.svh"

interface dec_if import pss_pkg::*; ();

    iq_sample_t            sample;
    logic                  valid;  // one-cycle strobe
    logic [`PSS_POS_W-1:0] pos;
    logic                  clear;  // empties the correlator windows

    modport source (
        output sample,
        output valid,
        output pos,
        output clear
    );

    modport sink (
        input sample,
        input valid,
        input pos,
        input clear
    );

endinterface

// File: logic/pss_decimator.sv
`timescale 1ns/1ns
`include "pss_settings.svh"

module pss_decimator import pss_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  iq_sample_t sample_i,
    input  logic       sample_valid_i,
    dec_if.source      dec
);

    localparam int IQ_W  = `PSS_IQ_W;
    localparam int POS_W = `PSS_POS_W;

    iq_sample_t              held_q;
    logic                    phase_q;  // high when the first of a pair is held
    logic                    reset_d_q;
    logic [POS_W-1:0]        cnt_q;
    logic signed [IQ_W:0]    sum_i;
    logic signed [IQ_W:0]    sum_q;
    logic                    pair_done;

    // one extra bit so the pair sum cannot overflow
    assign sum_i = held_q.i + sample_i.i;
    assign sum_q = held_q.q + sample_i.q;

    assign pair_done = sample_valid_i && phase_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            phase_q   <= 1'b0;
            reset_d_q <= 1'b1;
            cnt_q     <= '0;
            dec.valid <= 1'b0;
            dec.clear <= 1'b0;
        end else begin
            reset_d_q <= 1'b0;
            dec.clear <= reset_d_q; // single pulse after reset
            dec.valid <= pair_done;
            if (sample_valid_i) begin
                phase_q <= ~phase_q;
            end
            if (pair_done) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i && !phase_q) begin
            held_q <= sample_i;
        end
        if (pair_done) begin
            dec.sample.i <= sum_i[IQ_W:1]; // arithmetic shift by one
            dec.sample.q <= sum_q[IQ_W:1];
            dec.pos      <= cnt_q;
        end
    end

endmodule

// File: logic/pss_correlator.sv
`timescale 1ns/1ns
`include "pss_settings.svh"

module pss_correlator import pss_pkg::*; #(
    parameter int N_ID_2 = 0
) (
    input  logic         clk_i,
    input  logic         reset_i,
    dec_if.sink          dec,
    output corr_result_t result_o
);

    localparam int WIN    = `PSS_WIN_LEN;
    localparam int SUM_W  = `PSS_IQ_W + $clog2(WIN) + 1;
    localparam int FILL_W = $clog2(WIN);
    localparam int MW     = `PSS_METRIC_W;
    localparam int POS_W  = `PSS_POS_W;

    logic [WIN-1:0]          tap_neg;
    iq_sample_t              hist_q [WIN-1]; // older samples, hist_q[0] newest
    iq_sample_t              win [WIN];      // window including the new sample
    logic [FILL_W-1:0]       fill_q;
    logic                    full;
    logic signed [SUM_W-1:0] sum_i;
    logic signed [SUM_W-1:0] sum_q;
    logic signed [SUM_W-1:0] sum_i_q;
    logic signed [SUM_W-1:0] sum_q_q;
    logic                    s1_valid_q;
    logic [POS_W-1:0]        s1_pos_q;
    logic [SUM_W-1:0]        abs_i;
    logic [SUM_W-1:0]        abs_q;
    logic [MW-1:0]           metric_q;
    logic [POS_W-1:0]        pos_q;
    logic                    valid_q;

    for (genvar k = 0; k < WIN; k++) begin : g_tap
        localparam logic TAP = pss_tap_bit(k, N_ID_2);
        assign tap_neg[k] = TAP;
    end

    always_comb begin
        win[0] = dec.sample;
        for (int j = 1; j < WIN; j++) begin
            win[j] = hist_q[j-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec.clear) begin
            for (int j = 0; j < WIN - 1; j++) begin
                hist_q[j] <= '0;
            end
        end else if (dec.valid) begin
            for (int j = 0; j < WIN - 1; j++) begin
                hist_q[j] <= win[j];
            end
        end
    end

    // warm-up count, saturates once the window is full
    assign full = (fill_q == FILL_W'(WIN - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i || dec.clear) begin
            fill_q <= '0;
        end else if (dec.valid && !full) begin
            fill_q <= fill_q + 1'b1;
        end
    end

    // tap k weights the sample from WIN-1-k strobes ago
    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int k = 0; k < WIN; k++) begin
            if (tap_neg[k]) begin
                sum_i = sum_i - win[WIN-1-k].i;
                sum_q = sum_q - win[WIN-1-k].q;
            end else begin
                sum_i = sum_i + win[WIN-1-k].i;
                sum_q = sum_q + win[WIN-1-k].q;
            end
        end
    end

    assign abs_i = sum_i_q[SUM_W-1] ? -sum_i_q : sum_i_q;
    assign abs_q = sum_q_q[SUM_W-1] ? -sum_q_q : sum_q_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid_q <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            s1_valid_q <= dec.valid && full;
            valid_q    <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        sum_i_q  <= sum_i; // stage 1
        sum_q_q  <= sum_q;
        s1_pos_q <= dec.pos;
        metric_q <= MW'(abs_i) + MW'(abs_q); // stage 2
        pos_q    <= s1_pos_q;
    end

    assign result_o = '{metric: metric_q, pos: pos_q, valid: valid_q};

endmodule

// File: logic/pss_peak_picker.sv
`timescale 1ns/1ns
`include "pss_settings.svh"

module pss_peak_picker import pss_pkg::*; (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  corr_result_t                     results_i [`PSS_NUM_HYP],
    input  logic [`PSS_METRIC_W-1:0]         threshold_i,
    output logic                             peak_valid_o,
    output logic [$clog2(`PSS_NUM_HYP)-1:0]  n_id_2_o,
    output logic [`PSS_POS_W-1:0]            peak_pos_o,
    output logic [`PSS_METRIC_W-1:0]         peak_metric_o
);

    localparam int NUM_HYP = `PSS_NUM_HYP;
    localparam int HYP_W   = $clog2(NUM_HYP);
    localparam int HOLDOFF = `PSS_HOLDOFF;
    localparam int HOLD_W  = $clog2(HOLDOFF);
    localparam int MW      = `PSS_METRIC_W;

    picker_state_t     state_q;
    logic [HOLD_W-1:0] hold_cnt_q;
    logic              any_valid;
    logic [HYP_W-1:0]  best_idx;
    logic [MW-1:0]     best_metric;
    logic              hit;

    // strict compare so a tie keeps the lower N_id_2
    always_comb begin
        any_valid   = 1'b0;
        best_idx    = '0;
        best_metric = results_i[0].metric;
        for (int h = 0; h < NUM_HYP; h++) begin
            any_valid = any_valid | results_i[h].valid;
            if (results_i[h].metric > best_metric) begin
                best_idx    = HYP_W'(h);
                best_metric = results_i[h].metric;
            end
        end
    end

    assign hit = any_valid && (state_q == SEARCH) && (best_metric >= threshold_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= SEARCH;
            hold_cnt_q   <= '0;
            peak_valid_o <= 1'b0;
        end else begin
            peak_valid_o <= hit;
            case (state_q)
                SEARCH: begin
                    if (hit) begin
                        state_q    <= HOLD;
                        hold_cnt_q <= '0;
                    end
                end
                HOLD: begin
                    if (any_valid) begin
                        hold_cnt_q <= hold_cnt_q + 1'b1;
                        if (hold_cnt_q == HOLD_W'(HOLDOFF - 1)) begin
                            state_q <= SEARCH; // last ignored event
                        end
                    end
                end
                default: state_q <= SEARCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit) begin
            n_id_2_o      <= best_idx;
            peak_pos_o    <= results_i[0].pos; // same position in every correlator
            peak_metric_o <= best_metric;
        end
    end

endmodule

// File: logic/pss_search_top.sv
`timescale 1ns/1ns
`include "pss_settings.svh"

module pss_search_top import pss_pkg::*; (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic [2*`PSS_IQ_W-1:0]           sample_i,    // I high, Q low
    input  logic                             sample_valid_i,
    input  logic [`PSS_METRIC_W-1:0]         threshold_i,
    output logic                             peak_valid_o,
    output logic [$clog2(`PSS_NUM_HYP)-1:0]  n_id_2_o,
    output logic [`PSS_POS_W-1:0]            peak_pos_o,
    output logic [`PSS_METRIC_W-1:0]         peak_metric_o
);

    corr_result_t results [`PSS_NUM_HYP];

    dec_if dec_bus ();

    pss_decimator u_decimator (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sample_i       (iq_sample_t'(sample_i)),
        .sample_valid_i (sample_valid_i),
        .dec            (dec_bus)
    );

    // one correlator per N_id_2 hypothesis
    for (genvar g = 0; g < `PSS_NUM_HYP; g++) begin : g_corr
        pss_correlator #(
            .N_ID_2 (g)
        ) u_correlator (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .dec      (dec_bus),
            .result_o (results[g])
        );
    end

    pss_peak_picker u_peak_picker (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .results_i     (results),
        .threshold_i   (threshold_i),
        .peak_valid_o  (peak_valid_o),
        .n_id_2_o      (n_id_2_o),
        .peak_pos_o    (peak_pos_o),
        .peak_metric_o (peak_metric_o)
    );

endmodule

// File: bench/pss_model.svh
`ifndef PSS_MODEL_SVH
`define PSS_MODEL_SVH

int dec_hist_i [$]; // decimated stream since reset
int dec_hist_q [$];
int hold_left;      // events still ignored after a detection

// m-sequence bit as +1 or -1, read 43 places further per N_id_2
function automatic int tap_sign(input int k, input int nid);
    int         x [127];
    logic [6:0] start;
    start = 7'b1110110;
    for (int n = 0; n < 7; n++) begin
        x[n] = int'(start[n]);
    end
    for (int n = 0; n + 7 < 127; n++) begin
        x[n+7] = x[n+4] ^ x[n];
    end
    return (x[(k + 43 * nid) % 127] == 1) ? -1 : 1;
endfunction

function automatic int pair_average(input int a, input int b);
    return (a + b) >>> 1; // floor of the mean
endfunction

// |I| + |Q| of the window ending at decimated sample last
function automatic int window_metric(input int last, input int nid);
    int si;
    int sq;
    si = 0;
    sq = 0;
    for (int k = 0; k < `PSS_WIN_LEN; k++) begin
        si += tap_sign(k, nid) * dec_hist_i[last - `PSS_WIN_LEN + 1 + k];
        sq += tap_sign(k, nid) * dec_hist_q[last - `PSS_WIN_LEN + 1 + k];
    end
    return (si < 0 ? -si : si) + (sq < 0 ? -sq : sq);
endfunction

// lowest N_id_2 wins a tie
function automatic int best_hyp(input int last);
    int best;
    best = 0;
    for (int h = 1; h < `PSS_NUM_HYP; h++) begin
        if (window_metric(last, h) > window_metric(last, best)) begin
            best = h;
        end
    end
    return best;
endfunction

task automatic picker_step(input int pos, input int thr, output bit found,
                           output int nid, output int metric);
    nid    = best_hyp(pos);
    metric = window_metric(pos, nid);
    found  = 1'b0;
    if (hold_left > 0) begin
        hold_left--;
    end else if (metric >= thr) begin
        found     = 1'b1;
        hold_left = `PSS_HOLDOFF;
    end
endtask

`endif

// File: bench/pss_search_tb.sv
`timescale 1ns/1ns
`include "pss_settings.svh"

module pss_search_tb;

    localparam int NUM_ROWS = 10;
    localparam int WIN      = `PSS_WIN_LEN;
    localparam int IQ_W     = `PSS_IQ_W;
    localparam int MW       = `PSS_METRIC_W;
    localparam int HYP_W    = $clog2(`PSS_NUM_HYP);

    typedef struct {
        string name;
        int    n_id_2;
        int    amp;
        int    noise;
        int    gap;     // noise samples before each burst
        int    reps;
        int    thr;
        int    thr_rel; // thr is an offset from the peak metric
        int    skew;    // splits each pair into unequal halves
    } test_row_t;

    logic                  clk_i;
    logic                  reset_i;
    logic [2*IQ_W-1:0]     sample_i;
    logic                  sample_valid_i;
    logic [MW-1:0]         threshold_i;
    logic                  peak_valid_o;
    logic [HYP_W-1:0]      n_id_2_o;
    logic [`PSS_POS_W-1:0] peak_pos_o;
    logic [MW-1:0]         peak_metric_o;

    test_row_t rows [NUM_ROWS];
    int        in_i [$]; // input samples of the current row, in pairs
    int        in_q [$];
    int        exp_nid [$];
    int        exp_pos [$];
    int        exp_metric [$];
    string     exp_test [$];
    string     cur_test;
    int        watchdog_cycles;
    int        thr;

    `include "pss_model.svh"

    pss_search_top u_pss_search_top (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .threshold_i    (threshold_i),
        .peak_valid_o   (peak_valid_o),
        .n_id_2_o       (n_id_2_o),
        .peak_pos_o     (peak_pos_o),
        .peak_metric_o  (peak_metric_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic fail_run(input string msg);
        $display("ERROR: %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string what, input int expected,
                               input int actual);
        if (expected != actual) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic set_row(input int r, input string name, input int nid, input int amp,
                           input int noise, input int gap, input int reps, input int t,
                           input int rel, input int skew);
        rows[r] = '{name, nid, amp, noise, gap, reps, t, rel, skew};
    endtask

    task automatic load_table();
        //          name             nid amp noise gap reps thr  rel skew
        set_row(0, "noise_only",     0,  0,  3,   40,  1, 400, 0,  0);
        set_row(1, "clean_n0",       0, 40,  0,   20,  1, 800, 0,  0);
        set_row(2, "clean_n1",       1, 40,  0,   20,  1, 800, 0,  0);
        set_row(3, "clean_n2",       2, 40,  0,   20,  1, 800, 0,  0);
        set_row(4, "pair_average",   1, 30,  2,   20,  1, 560, 0,  9);
        set_row(5, "holdoff_close",  2, 40,  1,    3,  2, 300, 0,  0);
        set_row(6, "holdoff_far",    0, 40,  1,   12,  2, 800, 0,  0);
        set_row(7, "thr_above",      1, 32,  0,   20,  1,   1, 1,  0);
        set_row(8, "thr_equal",      1, 32,  0,   20,  1,   0, 1,  0);
        set_row(9, "tie_zero",       2,  0,  0,   30,  1,   0, 0,  0);
    endtask

    function automatic int noise_value(input int mag);
        int unsigned span;
        span = 2 * mag + 1;
        return int'($urandom % span) - mag;
    endfunction

    task automatic build_row(input int r);
        int s;
        int vi;
        int vq;
        int odd;
        in_i.delete();
        in_q.delete();
        odd = (rows[r].skew != 0) ? 1 : 0;
        for (int b = 0; b < rows[r].reps; b++) begin
            for (int n = 0; n < rows[r].gap + WIN; n++) begin
                s = (n >= rows[r].gap) ? tap_sign(n - rows[r].gap, rows[r].n_id_2) : 0;
                vi = s * rows[r].amp + noise_value(rows[r].noise);
                vq = -s * (rows[r].amp / 2) + noise_value(rows[r].noise);
                in_i.push_back(vi + rows[r].skew);
                in_q.push_back(vq + rows[r].skew);
                in_i.push_back(vi - rows[r].skew - odd);
                in_q.push_back(vq - rows[r].skew - odd);
            end
        end
    endtask

    task automatic predict_row(input int r, output int t);
        int first;
        int last;
        bit found;
        int nid;
        int metric;
        first = dec_hist_i.size();
        for (int n = 0; n < in_i.size(); n += 2) begin
            dec_hist_i.push_back(pair_average(in_i[n], in_i[n+1]));
            dec_hist_q.push_back(pair_average(in_q[n], in_q[n+1]));
        end
        last = dec_hist_i.size() - 1; // end of the last burst
        t = rows[r].thr;
        if (rows[r].thr_rel != 0) begin
            t += window_metric(last, best_hyp(last));
        end
        for (int p = first; p <= last; p++) begin
            if (p >= WIN - 1) begin
                picker_step(p, t, found, nid, metric);
                if (found) begin
                    exp_nid.push_back(nid);
                    exp_pos.push_back(p);
                    exp_metric.push_back(metric);
                    exp_test.push_back(rows[r].name);
                end
            end
        end
    endtask

    task automatic drive_row();
        int idle;
        for (int n = 0; n < in_i.size(); n++) begin
            idle = $urandom % 3;
            repeat (idle) @(negedge clk_i);
            sample_i       = {IQ_W'(in_i[n]), IQ_W'(in_q[n])};
            sample_valid_i = 1'b1;
            @(negedge clk_i);
            sample_valid_i = 1'b0;
        end
        repeat (8) @(negedge clk_i); // let the pipeline drain
    endtask

    function automatic int run_length();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += 2 * (rows[r].gap + WIN) * rows[r].reps;
        end
        return 4 * total + 20 * NUM_ROWS + 100;
    endfunction

    always @(negedge clk_i) begin
        if (!reset_i && peak_valid_o) begin
            if (exp_nid.size() == 0) begin
                fail_run($sformatf("unexpected peak report at position %0d during %s",
                                   peak_pos_o, cur_test));
            end else begin
                check_value(exp_test[0], "n_id_2", exp_nid[0], int'(n_id_2_o));
                check_value(exp_test[0], "position", exp_pos[0], int'(peak_pos_o));
                check_value(exp_test[0], "metric", exp_metric[0], int'(peak_metric_o));
                void'(exp_nid.pop_front());
                void'(exp_pos.pop_front());
                void'(exp_metric.pop_front());
                void'(exp_test.pop_front());
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk_i);
        fail_run($sformatf("watchdog timeout after %0d cycles", watchdog_cycles));
    end

    initial begin
        clk_i          = 1'b0;
        reset_i        = 1'b1;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        threshold_i    = '1;
        hold_left      = 0;
        cur_test       = "reset";
        void'($urandom(32'hc3fe_8537));
        load_table();
        watchdog_cycles = run_length();
        repeat (16) @(negedge clk_i);
        reset_i = 1'b0;
        repeat (4) @(negedge clk_i);
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_test = rows[r].name;
            build_row(r);
            predict_row(r, thr);
            threshold_i = MW'(thr);
            drive_row();
        end
        if (exp_nid.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_run($sformatf("missing peak report from %s at position %0d",
                               exp_test[0], exp_pos[0]));
        end
    end

endmodule

// File: vlog.f
+incdir+logic
+incdir+bench
logic/pss_pkg.sv
logic/dec_if.sv
logic/pss_decimator.sv
logic/pss_correlator.sv
logic/pss_peak_picker.sv
logic/pss_search_top.sv
bench/pss_search_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the PSS search testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/pss_search_sim

verilator --binary --timing -Wno-fatal --top-module pss_search_tb -f vlog.f -o pss_search_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
